// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module tb_forward -f sim.f -o tb_forward > sim.log 2>&1
	./obj_dir/tb_forward >> sim.log 2>&1
	@cat sim.log
	@! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== activation_buffer.sv ====
module activation_buffer import nn_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          load,
    input  act_vec_t      start_input,
    input  layer_result_t result,
    output act_vec_t      layer_input
);

    // vector kept between passes
    act_vec_t held;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // outside vector at run start, layer values after each pass
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (load) begin
            held <= start_input;
        end else if (result.valid) begin
            held <= result.values;
        end
    end

    ////////////////////////////////////////
    // output
    ////////////////////////////////////////

    // fresh results show up in their valid cycle
    // neurons are idle then, so the bypass only affects the final output
    assign layer_input = result.valid ? result.values : held;

    // a run is never launched while a pass is finishing
    a_load_vs_result: assert property (@(posedge clk) disable iff (rst)
        !(load && result.valid));

endmodule

// ==== forward.sv ====
`include "nn_cfg.svh"

module forward import nn_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  act_vec_t               start_input,
    input  logic [`NN_LAYER_W-1:0] layer_count,
    input  weight_mat_t            weights,
    output logic [`NN_LAYER_W-1:0] layer_index,
    output act_vec_t               final_output,
    output logic                   final_output_valid
);

    layer_cmd_t    cmd;
    logic          load;
    layer_result_t result;
    act_vec_t      layer_input;

    ////////////////////////////////////////
    // producer, buffer, consumer
    ////////////////////////////////////////

    layer_controller i_layer_controller (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .layer_count        (layer_count),
        .result             (result),
        .cmd                (cmd),
        .load               (load),
        .final_output_valid (final_output_valid)
    );

    activation_buffer i_activation_buffer (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .start_input (start_input),
        .result      (result),
        .layer_input (layer_input)
    );

    neuron_layer i_neuron_layer (
        .clk     (clk),
        .rst     (rst),
        .start   (cmd.start),
        .inputs  (layer_input),
        .weights (weights),
        .result  (result)
    );

    // external weight memory is addressed by the pass index
    assign layer_index  = cmd.index;
    assign final_output = layer_input;

endmodule

// ==== layer_controller.sv ====
`include "nn_cfg.svh"

module layer_controller import nn_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [`NN_LAYER_W-1:0] layer_count,
    input  layer_result_t          result,
    output layer_cmd_t             cmd,
    output logic                   load,
    output logic                   final_output_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LAUNCH,
        ST_WAIT
    } state_t;

    state_t                 state;
    logic                   busy;
    logic                   last;
    logic [`NN_LAYER_W-1:0] count_q;
    logic [`NN_LAYER_W-1:0] index_q;

    ////////////////////////////////////////
    // decoded outputs
    ////////////////////////////////////////

    assign busy = (state != ST_IDLE);

    // buffer takes start_input on the accepting edge
    assign load = start && !busy;

    // one cycle launch per pass
    assign cmd.start = (state == ST_LAUNCH);
    assign cmd.index = index_q;

    // current pass is the final one
    assign last = (index_q == `NN_LAYER_W'(count_q - 1'b1));

    // same cycle as the layer result, no extra latency
    assign final_output_valid = (state == ST_WAIT) && result.valid && last;

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            count_q <= '0;
            index_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // start during a run never reaches here
                    if (start) begin
                        count_q <= layer_count;
                        index_q <= '0;
                        state   <= ST_LAUNCH;
                    end
                end
                ST_LAUNCH: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (result.valid) begin
                        if (last) begin
                            state <= ST_IDLE;
                        end else begin
                            // next pass reads weights of the new index
                            index_q <= index_q + 1'b1;
                            state   <= ST_LAUNCH;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // accepted runs must ask for 1 .. max layers
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        load |-> (layer_count != '0) && (int'(layer_count) <= `NN_LAYER_MAX));

    // every launch is answered before the next one
    a_pass_answered: assert property (@(posedge clk) disable iff (rst)
        cmd.start |-> ##(`NN_NUM_NEURON + 1) result.valid);

endmodule

// ==== neuron.sv ====
`include "nn_cfg.svh"

module neuron import nn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  act_t        x,
    input  weight_row_t w_row,
    output act_t        y,
    output logic        valid
);

    localparam int STEP_W = $clog2(`NN_NUM_NEURON);
    // unsigned activation widened by one sign bit, times weight
    localparam int PROD_W = `NN_ACT_W + 1 + `NN_WEIGHT_W;
    // product carries both fraction parts, keep the activation format
    localparam int DROP = (`NN_ACT_FRAC + `NN_WEIGHT_FRAC) - `NN_ACT_FRAC;

    logic [STEP_W-1:0]           step;
    logic                        busy;
    logic                        fin;
    logic [STEP_W-1:0]           w_sel;
    weight_t                     w_cur;
    logic signed [`NN_ACT_W:0]   x_s;
    logic signed [PROD_W-1:0]    prod;
    logic signed [`NN_ACC_W-1:0] prod_ext;
    acc_u                        acc;
    act_t                        y_next;

    ////////////////////////////////////////
    // multiply path
    ////////////////////////////////////////

    // first step is taken in the start cycle itself
    assign w_sel    = start ? '0 : step;
    assign w_cur    = w_row[w_sel];
    assign x_s      = $signed({1'b0, x});
    assign prod     = x_s * w_cur;
    // sign extend then arithmetic shift
    assign prod_ext = prod >>> DROP;

    // relu and saturation from the union fields
    always_comb begin
        if (acc.raw[`NN_ACC_W-1])
            y_next = '0;
        else if (acc.fields.over != '0)
            y_next = '1;
        else
            y_next = acc.fields.act;
    end

    // step sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            step  <= '0;
            busy  <= 1'b0;
            fin   <= 1'b0;
            valid <= 1'b0;
        end else begin
            valid <= fin;
            fin   <= 1'b0;
            if (start) begin
                step <= STEP_W'(1);
                busy <= 1'b1;
            end else if (busy) begin
                if (step == STEP_W'(`NN_NUM_NEURON - 1)) begin
                    step <= '0;
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // sum and output word
    always_ff @(posedge clk) begin
        // start restarts the sum from zero
        if (start)
            acc.raw <= prod_ext;
        else if (busy)
            acc.raw <= acc.raw + prod_ext;
        if (fin)
            y <= y_next;
    end

    // controller must wait for the previous pass to finish
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> !(busy || fin));

endmodule

// ==== neuron_layer.sv ====
`include "nn_cfg.svh"

module neuron_layer import nn_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  act_vec_t      inputs,
    input  weight_mat_t   weights,
    output layer_result_t result
);

    localparam int STEP_W = $clog2(`NN_NUM_NEURON);

    logic [STEP_W-1:0]         step;
    logic [STEP_W-1:0]         sel;
    act_t                      x;
    act_vec_t                  y;
    logic [`NN_NUM_NEURON-1:0] valid;

    ////////////////////////////////////////
    // shared input stream
    ////////////////////////////////////////

    // element 0 goes out together with start
    assign sel = start ? '0 : step;
    assign x   = inputs[sel];

    // walks 1 .. N-1 after start, then parks at 0
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (start) begin
            step <= STEP_W'(1);
        end else if (step != '0) begin
            if (step == STEP_W'(`NN_NUM_NEURON - 1))
                step <= '0;
            else
                step <= step + 1'b1;
        end
    end

    ////////////////////////////////////////
    // neuron array
    ////////////////////////////////////////

    for (genvar i = 0; i < `NN_NUM_NEURON; i++) begin : g_neuron
        neuron i_neuron (
            .clk   (clk),
            .rst   (rst),
            .start (start),
            .x     (x),
            .w_row (weights[i]),
            .y     (y[i]),
            .valid (valid[i])
        );
    end

    // lockstep, so neuron 0 speaks for all
    assign result.valid  = valid[0];
    assign result.values = y;

    a_valid_lockstep: assert property (@(posedge clk) disable iff (rst)
        (&valid) == (|valid));

endmodule

// ==== nn_cfg.svh ====
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

////////////////////////////////////////
// layer geometry
////////////////////////////////////////

// neurons per physical layer, also inputs per neuron
`define NN_NUM_NEURON 5

////////////////////////////////////////
// number formats
////////////////////////////////////////

// activations, unsigned Q1.8
`define NN_ACT_W      9
`define NN_ACT_FRAC   8
// weights, signed with 8 fraction bits
`define NN_WEIGHT_W   17
`define NN_WEIGHT_FRAC 8
// running sum inside each neuron
`define NN_ACC_W      32

// layer recirculation limits
`define NN_LAYER_MAX  3
`define NN_LAYER_W    2

`endif

// ==== nn_pkg.sv ====
`include "nn_cfg.svh"

package nn_pkg;

    // one activation, never negative after relu
    typedef logic [`NN_ACT_W-1:0] act_t;
    // one full layer vector
    typedef act_t [`NN_NUM_NEURON-1:0] act_vec_t;

    // signed fixed point weight
    typedef logic signed [`NN_WEIGHT_W-1:0] weight_t;
    // all weights feeding one neuron
    typedef weight_t [`NN_NUM_NEURON-1:0] weight_row_t;
    // one row per neuron, whole layer
    typedef weight_row_t [`NN_NUM_NEURON-1:0] weight_mat_t;

    // accumulator, seen as a signed sum or split for saturation
    typedef union packed {
        logic signed [`NN_ACC_W-1:0] raw;
        struct packed {
            logic [`NN_ACC_W-`NN_ACT_W-1:0] over;
            logic [`NN_ACT_W-1:0]           act;
        } fields;
    } acc_u;

    // controller to layer and weight port
    typedef struct packed {
        logic                   start;
        logic [`NN_LAYER_W-1:0] index;
    } layer_cmd_t;

    // layer back to buffer and controller
    typedef struct packed {
        logic     valid;
        act_vec_t values;
    } layer_result_t;

endpackage

// ==== sim.f ====
+incdir+.
nn_pkg.sv
neuron.sv
neuron_layer.sv
activation_buffer.sv
layer_controller.sv
forward.sv
tb_forward.sv

// ==== tb_forward.sv ====
`include "nn_cfg.svh"

module tb_forward import nn_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT  = 200;
    localparam int PASS_CYC = `NN_NUM_NEURON + 2;

    logic                   clk         = 1'b0;
    logic                   rst         = 1'b1;
    logic                   start       = 1'b0;
    act_vec_t               start_input = '0;
    logic [`NN_LAYER_W-1:0] layer_count = `NN_LAYER_W'(1);
    weight_mat_t            weights     = '0;
    logic [`NN_LAYER_W-1:0] layer_index;
    act_vec_t               final_output;
    logic                   final_output_valid;

    // external weight memory, one matrix per layer
    weight_mat_t wtab [`NN_LAYER_MAX];
    logic [31:0] rng = 32'd47796;

    int    errors = 0;
    int    checks = 0;
    int    tests  = 0;
    int    failed = 0;
    int    err_mark;
    string cur_name;

    forward i_forward (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .start_input        (start_input),
        .layer_count        (layer_count),
        .weights            (weights),
        .layer_index        (layer_index),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    always #2 clk = ~clk;

    // memory answers the presented index just after each edge
    always @(posedge clk) begin
        #0.5;
        if (int'(layer_index) < `NN_LAYER_MAX)
            weights = wtab[layer_index];
        else
            weights = '0;
    end

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic act_vec_t rand_vec();
        act_vec_t v;
        for (int i = 0; i < `NN_NUM_NEURON; i++)
            v[i] = act_t'(xorshift());
        return v;
    endfunction

    function automatic weight_t rand_weight();
        logic [31:0] r;
        r = xorshift();
        // one in eight is large, up to about 16.0 either sign
        if (r[2:0] == 3'd0)
            return r[31] ? -weight_t'(r[19:8]) : weight_t'(r[19:8]);
        // rest within about +-1.0
        return weight_t'(int'(r[16:8]) - 256);
    endfunction

    task automatic fill_table();
        for (int l = 0; l < `NN_LAYER_MAX; l++)
            for (int i = 0; i < `NN_NUM_NEURON; i++)
                for (int j = 0; j < `NN_NUM_NEURON; j++)
                    wtab[l][i][j] = rand_weight();
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // each product floors off the weight fraction before the sum
    function automatic act_vec_t model_layer(act_vec_t xin, weight_mat_t w);
        act_vec_t y;
        longint   acc;
        longint   p;
        for (int i = 0; i < `NN_NUM_NEURON; i++) begin
            acc = 0;
            for (int j = 0; j < `NN_NUM_NEURON; j++) begin
                p = longint'(xin[j]) * longint'(w[i][j]);
                acc += p >>> `NN_WEIGHT_FRAC;
            end
            // relu, then clamp to the activation range
            if (acc < 0)
                y[i] = '0;
            else if (acc > longint'((1 << `NN_ACT_W) - 1))
                y[i] = '1;
            else
                y[i] = act_t'(acc);
        end
        return y;
    endfunction

    function automatic act_vec_t model_forward(act_vec_t vin, int lc);
        act_vec_t v;
        v = vin;
        for (int l = 0; l < lc; l++)
            v = model_layer(v, wtab[l]);
        return v;
    endfunction

    ////////////////////////////////////////
    // compare tasks and test bookkeeping
    ////////////////////////////////////////

    task automatic check_vec(input string name, input act_vec_t exp, input act_vec_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_index(input string name, input logic [`NN_LAYER_W-1:0] exp,
                               input logic [`NN_LAYER_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            $display("FAIL %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors != err_mark) begin
            failed++;
            $display("test %s: failed with %0d errors", cur_name, errors - err_mark);
        end else begin
            $display("test %s: ok", cur_name);
        end
    endtask

    ////////////////////////////////////////
    // run sequencing
    ////////////////////////////////////////

    // one cycle start pulse, returns just after the accepting edge
    task automatic launch(input act_vec_t vin, input int lc);
        @(posedge clk);
        #0.5;
        start       = 1'b1;
        start_input = vin;
        layer_count = `NN_LAYER_W'(lc);
        @(posedge clk);
        #0.5;
        start = 1'b0;
    endtask

    // values seen 1 ns after edge n are the ones edge n+1 samples
    task automatic wait_valid(input string name, input int busy_start,
                              output int lat, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            n++;
            // optional second start in the middle of the run
            if (n == busy_start) begin
                start       = 1'b1;
                start_input = rand_vec();
                layer_count = `NN_LAYER_W'(3);
            end else begin
                start = 1'b0;
            end
            #0.5;
            // index moves on once per pass
            check_index({name, " index"}, `NN_LAYER_W'(n / PASS_CYC), layer_index);
            ok = final_output_valid;
        end
        lat = n + 1;
        if (!ok) begin
            $display("%s: final_output_valid never arrived within %0d cycles", name, TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_checked(input string name, input act_vec_t vin, input int lc,
                               input act_vec_t exp, input int busy_start, input int quiet);
        int lat;
        bit ok;
        int extra;
        launch(vin, lc);
        wait_valid(name, busy_start, lat, ok);
        if (ok) begin
            check_count({name, " latency"}, lc * PASS_CYC, lat);
            check_vec({name, " output"}, exp, final_output);
            extra = 0;
            repeat (quiet) begin
                @(posedge clk);
                #1;
                if (final_output_valid)
                    extra++;
            end
            if (extra != 0) begin
                $display("%s: %0d unexpected final_output_valid pulses", name, extra);
                errors++;
            end
            // buffer keeps the last layer values
            check_vec({name, " held"}, exp, final_output);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        act_vec_t vin;
        act_vec_t fixed;
        int       lc;
        int       stray;

        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;

        begin_test("single_layer");
        fill_table();
        vin = rand_vec();
        run_checked("single_layer", vin, 1, model_forward(vin, 1), 0, PASS_CYC);
        end_test();

        begin_test("multi_layer");
        for (int k = 2; k <= 3; k++) begin
            fill_table();
            vin = rand_vec();
            run_checked($sformatf("multi_layer_%0d", k), vin, k, model_forward(vin, k),
                        0, PASS_CYC);
        end
        end_test();

        // 8.0 weights on 1.0 inputs, far above the range
        begin_test("saturate_high");
        for (int i = 0; i < `NN_NUM_NEURON; i++) begin
            vin[i] = act_t'(256);
            for (int j = 0; j < `NN_NUM_NEURON; j++)
                wtab[0][i][j] = weight_t'(2048);
        end
        fixed = '1;
        run_checked("saturate_high", vin, 1, fixed, 0, PASS_CYC);
        end_test();

        begin_test("relu_zero");
        for (int i = 0; i < `NN_NUM_NEURON; i++)
            for (int j = 0; j < `NN_NUM_NEURON; j++)
                wtab[0][i][j] = weight_t'(-256);
        vin   = rand_vec();
        fixed = '0;
        run_checked("relu_zero", vin, 1, fixed, 0, PASS_CYC);
        end_test();

        // decoy start in cycle 3, long quiet window for any stray run
        begin_test("start_while_busy");
        fill_table();
        vin = rand_vec();
        run_checked("start_while_busy", vin, 2, model_forward(vin, 2), 3,
                    3 * PASS_CYC + 2);
        end_test();

        begin_test("reset_mid_run");
        fill_table();
        launch(rand_vec(), 3);
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;
        #0.5;
        check_index("reset_mid_run index", '0, layer_index);
        stray = 0;
        repeat (TIMEOUT) begin
            @(posedge clk);
            #1;
            if (final_output_valid)
                stray++;
        end
        if (stray != 0) begin
            $display("reset_mid_run: final_output_valid pulsed after reset");
            errors++;
        end
        vin = rand_vec();
        run_checked("reset_mid_run rerun", vin, 3, model_forward(vin, 3), 0, PASS_CYC);
        end_test();

        begin_test("random_regression");
        for (int k = 0; k < 40; k++) begin
            fill_table();
            vin = rand_vec();
            lc  = 1 + int'(xorshift() % 3);
            run_checked($sformatf("random_%0d", k), vin, lc, model_forward(vin, lc),
                        0, PASS_CYC);
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
